// ==== cpuPkg.sv ====
package cpuPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and architectural constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // PC after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;
    // Link register for JAL
    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E
    } opcodeE;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_JR  = 6'h08,
        FN_MUL = 6'h18,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_NOR = 6'h27,
        FN_SLT = 6'h2A
    } functE;

    ////////////////////////////////////////////////////////////////////////////
    // Control word
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_AND, ALU_OR, ALU_NOR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_PASS_LINK
    } aluOpE;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LTZ, BR_GEZ, BR_LEZ, BR_GTZ
    } brCondE;

    // Shifts take rt on the A side
    typedef enum logic [0:0] {SRCA_RS, SRCA_RT} srcAE;
    typedef enum logic [1:0] {SRCB_RT, SRCB_SIMM, SRCB_ZIMM, SRCB_SHAMT} srcBE;
    typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_RA} destE;

    typedef struct packed {
        aluOpE  aluOp;
        srcAE   srcA;
        srcBE   srcB;
        destE   dest;
        brCondE brCond;
        logic   isJump;
        logic   jumpReg;
        logic   regWrite;
        logic   illegal;
    } ctrlT;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////////////////////////////////////////

    // Input link payload
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } inItemT;

    // Decode stage output
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] destReg;
        logic [15:0]           imm16;
        logic [4:0]            shamt;
        logic [25:0]           jumpIdx;
        ctrlT                  ctrl;
    } decT;

    // Operand stage output
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       opA;
        logic [XLEN-1:0]       opB;
        logic [XLEN-1:0]       rsVal;
        logic [XLEN-1:0]       rtVal;
        logic [REG_ADDR_W-1:0] destReg;
        logic [15:0]           imm16;
        logic [25:0]           jumpIdx;
        ctrlT                  ctrl;
    } opT;

    // Retire record
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic                  wrEn;
        logic [REG_ADDR_W-1:0] wrReg;
        logic [XLEN-1:0]       wrData;
        logic                  redirect;
        logic [XLEN-1:0]       target;
        logic                  illegal;
    } retireT;

endpackage

// ==== instrBuffer.sv ====
`timescale 1ns/1ns

module instrBuffer #(
    parameter int CREDITS = 4
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  cpuPkg::inItemT  inItem,
    input  logic            bufPop,
    output logic            bufValid,
    output cpuPkg::inItemT  bufItem,
    output logic            creditRet
);
    import cpuPkg::*;

    localparam int PTR_W = $clog2(CREDITS);
    localparam int CNT_W = $clog2(CREDITS + 1);

    // Storage, one slot per credit
    inItemT            mem [CREDITS];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [CNT_W-1:0]  count;

    // Wraps at CREDITS, depth need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign bufValid = (count != '0);
    assign bufItem  = mem[rdPtr];

    // Payload write
    always_ff @(posedge clk) begin
        if (inValid) begin
            mem[wrPtr] <= inItem;
        end
    end

    // Pointers, occupancy and credit return
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            creditRet <= 1'b0;
        end else begin
            if (inValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (bufPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({inValid, bufPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per released slot
            creditRet <= bufPop;
        end
    end

    // Sender must hold a credit, so a full buffer never sees a push
    assert property (@(posedge clk) disable iff (!rstN) inValid |-> count != CNT_W'(CREDITS))
        else $error("instrBuffer push while full");

    // Decoder pops only what is present
    assert property (@(posedge clk) disable iff (!rstN) bufPop |-> bufValid)
        else $error("instrBuffer pop while empty");

endmodule

// ==== ctrlDecoder.sv ====
`timescale 1ns/1ns

module ctrlDecoder (
    input  logic            clk,
    input  logic            rstN,
    input  logic            bufValid,
    input  cpuPkg::inItemT  bufItem,
    output logic            bufPop,
    output logic            decValid,
    output cpuPkg::decT     dec
);
    import cpuPkg::*;

    logic [XLEN-1:0]       instr;
    opcodeE                opcode;
    functE                 funct;
    ctrlT                  ctrl;
    logic [REG_ADDR_W-1:0] destReg;
    decT                   decNext;

    // Legal register-writing ALU instruction
    function automatic ctrlT aluCtrl(input aluOpE op, input srcAE a, input srcBE b,
                                     input destE d);
        ctrlT c;
        c          = '0;
        c.aluOp    = op;
        c.srcA     = a;
        c.srcB     = b;
        c.dest     = d;
        c.regWrite = 1'b1;
        return c;
    endfunction

    // Conditional branch, no write
    function automatic ctrlT brCtrl(input brCondE cond);
        ctrlT c;
        c        = '0;
        c.brCond = cond;
        return c;
    endfunction

    // Never stalls
    assign bufPop = bufValid;

    assign instr  = bufItem.instr;
    assign opcode = opcodeE'(instr[31:26]);
    assign funct  = functE'(instr[5:0]);

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Safe default, anything unmatched is illegal and writes nothing
        ctrl         = '0;
        ctrl.illegal = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADD: ctrl = aluCtrl(ALU_ADD, SRCA_RS, SRCB_RT, DEST_RD);
                    FN_SUB: ctrl = aluCtrl(ALU_SUB, SRCA_RS, SRCB_RT, DEST_RD);
                    FN_MUL: ctrl = aluCtrl(ALU_MUL, SRCA_RS, SRCB_RT, DEST_RD);
                    FN_AND: ctrl = aluCtrl(ALU_AND, SRCA_RS, SRCB_RT, DEST_RD);
                    FN_OR:  ctrl = aluCtrl(ALU_OR, SRCA_RS, SRCB_RT, DEST_RD);
                    FN_NOR: ctrl = aluCtrl(ALU_NOR, SRCA_RS, SRCB_RT, DEST_RD);
                    FN_XOR: ctrl = aluCtrl(ALU_XOR, SRCA_RS, SRCB_RT, DEST_RD);
                    FN_SLT: ctrl = aluCtrl(ALU_SLT, SRCA_RS, SRCB_RT, DEST_RD);
                    // Shifts operate on rt by shamt
                    FN_SLL: ctrl = aluCtrl(ALU_SLL, SRCA_RT, SRCB_SHAMT, DEST_RD);
                    FN_SRL: ctrl = aluCtrl(ALU_SRL, SRCA_RT, SRCB_SHAMT, DEST_RD);
                    FN_JR: begin
                        ctrl.illegal = 1'b0;
                        ctrl.isJump  = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    default: ;
                endcase
            end
            // rt picks the REGIMM branch flavour
            OP_REGIMM: begin
                if (instr[20:16] == 5'd0) begin
                    ctrl = brCtrl(BR_LTZ);
                end else if (instr[20:16] == 5'd1) begin
                    ctrl = brCtrl(BR_GEZ);
                end
            end
            OP_BEQ:  ctrl = brCtrl(BR_EQ);
            OP_BNE:  ctrl = brCtrl(BR_NE);
            OP_BLEZ: ctrl = brCtrl(BR_LEZ);
            OP_BGTZ: ctrl = brCtrl(BR_GTZ);
            OP_ADDI: ctrl = aluCtrl(ALU_ADD, SRCA_RS, SRCB_SIMM, DEST_RT);
            OP_SLTI: ctrl = aluCtrl(ALU_SLT, SRCA_RS, SRCB_SIMM, DEST_RT);
            // Logical immediates zero extend
            OP_ANDI: ctrl = aluCtrl(ALU_AND, SRCA_RS, SRCB_ZIMM, DEST_RT);
            OP_ORI:  ctrl = aluCtrl(ALU_OR, SRCA_RS, SRCB_ZIMM, DEST_RT);
            OP_XORI: ctrl = aluCtrl(ALU_XOR, SRCA_RS, SRCB_ZIMM, DEST_RT);
            OP_J: begin
                ctrl.illegal = 1'b0;
                ctrl.isJump  = 1'b1;
            end
            OP_JAL: begin
                ctrl        = aluCtrl(ALU_PASS_LINK, SRCA_RS, SRCB_RT, DEST_RA);
                ctrl.isJump = 1'b1;
            end
            default: ;
        endcase

        // Destination index
        case (ctrl.dest)
            DEST_RT: destReg = instr[20:16];
            DEST_RA: destReg = RA_REG;
            default: destReg = instr[15:11];
        endcase

        // r0 is hardwired, so nothing to commit
        // All-zero word lands here as SLL r0 and becomes a no-op
        if (destReg == '0) begin
            ctrl.regWrite = 1'b0;
        end
    end

    always_comb begin
        decNext.pc      = bufItem.pc;
        decNext.rs      = instr[25:21];
        decNext.rt      = instr[20:16];
        decNext.destReg = destReg;
        decNext.imm16   = instr[15:0];
        decNext.shamt   = instr[10:6];
        decNext.jumpIdx = instr[25:0];
        decNext.ctrl    = ctrl;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= bufValid;
        end
    end

    always_ff @(posedge clk) begin
        dec <= decNext;
    end

endmodule

// ==== operandStage.sv ====
`timescale 1ns/1ns

module operandStage (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            decValid,
    input  cpuPkg::decT                     dec,
    input  logic                            wbEn,
    input  logic [cpuPkg::REG_ADDR_W-1:0]   wbReg,
    input  logic [cpuPkg::XLEN-1:0]         wbData,
    output logic                            opValid,
    output cpuPkg::opT                      op
);
    import cpuPkg::*;

    // r1..r31, r0 is implied
    logic [XLEN-1:0] regs [1:31];
    logic [XLEN-1:0] rsVal;
    logic [XLEN-1:0] rtVal;
    opT              opNext;

    // Register read with bypass from the execute writeback
    function automatic logic [XLEN-1:0] readReg(input logic [REG_ADDR_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wbEn && wbReg == idx) begin
            val = wbData;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    // Register file, cleared on reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbReg != '0) begin
            regs[wbReg] <= wbData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rsVal = readReg(dec.rs);
        rtVal = readReg(dec.rt);

        opNext.pc      = dec.pc;
        opNext.rsVal   = rsVal;
        opNext.rtVal   = rtVal;
        opNext.destReg = dec.destReg;
        opNext.imm16   = dec.imm16;
        opNext.jumpIdx = dec.jumpIdx;
        opNext.ctrl    = dec.ctrl;

        opNext.opA = (dec.ctrl.srcA == SRCA_RT) ? rtVal : rsVal;

        case (dec.ctrl.srcB)
            SRCB_SIMM:  opNext.opB = {{(XLEN-16){dec.imm16[15]}}, dec.imm16};
            SRCB_ZIMM:  opNext.opB = {{(XLEN-16){1'b0}}, dec.imm16};
            SRCB_SHAMT: opNext.opB = {{(XLEN-5){1'b0}}, dec.shamt};
            default:    opNext.opB = rtVal;
        endcase
    end

    // Operand register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            opValid <= 1'b0;
        end else begin
            opValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        op <= opNext;
    end

endmodule

// ==== execStage.sv ====
`timescale 1ns/1ns

module execStage (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            opValid,
    input  cpuPkg::opT                      op,
    output logic                            wbEn,
    output logic [cpuPkg::REG_ADDR_W-1:0]   wbReg,
    output logic [cpuPkg::XLEN-1:0]         wbData,
    output logic                            retValid,
    output cpuPkg::retireT                  ret
);
    import cpuPkg::*;

    // Architectural next PC
    logic [XLEN-1:0] expectedPc;
    logic            live;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] aluResult;
    logic            condMet;
    logic            taken;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] nextPc;
    retireT          retNext;

    // Wrong-path work is dropped here
    assign live    = opValid && (op.pc == expectedPc);
    assign pcPlus4 = op.pc + XLEN'(4);

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op.ctrl.aluOp)
            ALU_ADD:       aluResult = op.opA + op.opB;
            ALU_SUB:       aluResult = op.opA - op.opB;
            ALU_MUL:       aluResult = op.opA * op.opB;
            ALU_AND:       aluResult = op.opA & op.opB;
            ALU_OR:        aluResult = op.opA | op.opB;
            ALU_NOR:       aluResult = ~(op.opA | op.opB);
            ALU_XOR:       aluResult = op.opA ^ op.opB;
            ALU_SLL:       aluResult = op.opA << op.opB[4:0];
            ALU_SRL:       aluResult = op.opA >> op.opB[4:0];
            ALU_SLT:       aluResult = XLEN'($signed(op.opA) < $signed(op.opB));
            // JAL link value
            ALU_PASS_LINK: aluResult = pcPlus4;
            default:       aluResult = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch and jump resolution
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op.ctrl.brCond)
            BR_EQ:   condMet = (op.rsVal == op.rtVal);
            BR_NE:   condMet = (op.rsVal != op.rtVal);
            BR_LTZ:  condMet = op.rsVal[XLEN-1];
            BR_GEZ:  condMet = !op.rsVal[XLEN-1];
            BR_LEZ:  condMet = op.rsVal[XLEN-1] || (op.rsVal == '0);
            BR_GTZ:  condMet = !op.rsVal[XLEN-1] && (op.rsVal != '0);
            default: condMet = 1'b0;
        endcase
        taken = condMet || op.ctrl.isJump;

        // JR, then J/JAL region jump, then PC-relative branch
        if (op.ctrl.jumpReg) begin
            target = op.rsVal;
        end else if (op.ctrl.isJump) begin
            target = {pcPlus4[XLEN-1:28], op.jumpIdx, 2'b00};
        end else begin
            target = pcPlus4 + {{(XLEN-18){op.imm16[15]}}, op.imm16, 2'b00};
        end
        nextPc = taken ? target : pcPlus4;
    end

    // Writeback, also the forwarding source
    assign wbEn   = live && op.ctrl.regWrite;
    assign wbReg  = op.destReg;
    assign wbData = aluResult;

    always_comb begin
        retNext.pc       = op.pc;
        retNext.wrEn     = wbEn;
        retNext.wrReg    = wbEn ? wbReg : '0;
        retNext.wrData   = wbEn ? wbData : '0;
        retNext.redirect = taken;
        retNext.target   = nextPc;
        retNext.illegal  = op.ctrl.illegal;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            expectedPc <= RESET_PC;
            retValid   <= 1'b0;
        end else begin
            retValid <= live;
            if (live) begin
                expectedPc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        ret <= retNext;
    end

    // Decoder masks r0 destinations before they reach writeback
    assert property (@(posedge clk) disable iff (!rstN) wbEn |-> wbReg != '0)
        else $error("execStage write to r0");

endmodule

// ==== pipeCore.sv ====
`timescale 1ns/1ns

module pipeCore #(
    parameter int CREDITS = 4
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  cpuPkg::inItemT  inItem,
    output logic            creditRet,
    output logic            retValid,
    output cpuPkg::retireT  ret
);
    import cpuPkg::*;

    // Buffer to decode
    logic                  bufValid;
    logic                  bufPop;
    inItemT                bufItem;
    // Decode to operand read
    logic                  decValid;
    decT                   dec;
    // Operand read to execute
    logic                  opValid;
    opT                    op;
    // Writeback and bypass
    logic                  wbEn;
    logic [REG_ADDR_W-1:0] wbReg;
    logic [XLEN-1:0]       wbData;

    instrBuffer #(
        .CREDITS (CREDITS)
    ) buf0 (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inItem    (inItem),
        .bufPop    (bufPop),
        .bufValid  (bufValid),
        .bufItem   (bufItem),
        .creditRet (creditRet)
    );

    ctrlDecoder dec0 (
        .clk      (clk),
        .rstN     (rstN),
        .bufValid (bufValid),
        .bufItem  (bufItem),
        .bufPop   (bufPop),
        .decValid (decValid),
        .dec      (dec)
    );

    operandStage opr0 (
        .clk      (clk),
        .rstN     (rstN),
        .decValid (decValid),
        .dec      (dec),
        .wbEn     (wbEn),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .opValid  (opValid),
        .op       (op)
    );

    execStage exe0 (
        .clk      (clk),
        .rstN     (rstN),
        .opValid  (opValid),
        .op       (op),
        .wbEn     (wbEn),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .retValid (retValid),
        .ret      (ret)
    );

endmodule

// ==== tbVectors.svh ====
// R-type word, opcode SPECIAL
function automatic logic [31:0] rTypeWord(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
endfunction

// I-type word, rt is the destination or REGIMM selector
function automatic logic [31:0] immWord(input logic [5:0] opc, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

function automatic logic [31:0] jumpWord(input logic [5:0] opc, input logic [25:0] idx);
    return {opc, idx};
endfunction

task automatic addVec(input logic [31:0] pc, input logic [31:0] instr);
    inItemT item;
    item.pc    = pc;
    item.instr = instr;
    vecQ.push_back(item);
endtask

// Table rows are (pc, instruction), wrong-path rows included
task automatic loadVectors();
    // Arithmetic and logic on r1 = 5, r2 = -3
    addVec(32'h00, immWord(OP_ADDI, 1, 0, 16'd5));
    addVec(32'h04, immWord(OP_ADDI, 2, 0, 16'hFFFD));
    addVec(32'h08, rTypeWord(FN_ADD, 3, 1, 2, 0));
    addVec(32'h0C, rTypeWord(FN_SUB, 4, 1, 2, 0));
    addVec(32'h10, rTypeWord(FN_MUL, 5, 1, 2, 0));
    addVec(32'h14, rTypeWord(FN_AND, 6, 5, 1, 0));
    addVec(32'h18, rTypeWord(FN_OR, 7, 1, 2, 0));
    addVec(32'h1C, rTypeWord(FN_NOR, 8, 1, 2, 0));
    addVec(32'h20, rTypeWord(FN_XOR, 9, 1, 2, 0));
    addVec(32'h24, rTypeWord(FN_SLL, 10, 0, 1, 4));
    addVec(32'h28, rTypeWord(FN_SRL, 11, 0, 2, 28));
    addVec(32'h2C, rTypeWord(FN_SLT, 12, 2, 1, 0));
    addVec(32'h30, immWord(OP_SLTI, 13, 1, 16'hFFFF));
    addVec(32'h34, immWord(OP_ANDI, 14, 2, 16'h8F0F));
    addVec(32'h38, immWord(OP_ORI, 15, 1, 16'h8000));
    addVec(32'h3C, immWord(OP_XORI, 16, 2, 16'hFFFF));
    // r0 target, then read r0 back
    addVec(32'h40, immWord(OP_ADDI, 0, 1, 16'd7));
    addVec(32'h44, rTypeWord(FN_ADD, 17, 0, 1, 0));
    addVec(32'h48, 32'h0000_0000);
    // LW and a bad function code
    addVec(32'h4C, immWord(6'h23, 8, 1, 16'h0000));
    addVec(32'h50, rTypeWord(6'h3F, 9, 1, 2, 0));
    // Branches, taken and not taken
    addVec(32'h54, immWord(OP_BEQ, 1, 1, 16'd2));
    addVec(32'h58, immWord(OP_ADDI, 20, 0, 16'd99));
    addVec(32'h5C, immWord(OP_ADDI, 1, 0, 16'd0));
    addVec(32'h60, immWord(OP_BNE, 1, 1, 16'd4));
    addVec(32'h64, immWord(OP_BNE, 2, 1, 16'd1));
    addVec(32'h68, immWord(OP_ADDI, 21, 0, 16'd1));
    addVec(32'h6C, immWord(OP_REGIMM, 0, 2, 16'd1));
    addVec(32'h70, immWord(OP_ADDI, 21, 0, 16'd2));
    addVec(32'h74, immWord(OP_REGIMM, 0, 1, 16'd5));
    addVec(32'h78, immWord(OP_REGIMM, 1, 1, 16'd1));
    addVec(32'h7C, immWord(OP_ADDI, 21, 0, 16'd3));
    addVec(32'h80, immWord(OP_REGIMM, 1, 2, 16'd3));
    addVec(32'h84, immWord(OP_BLEZ, 0, 0, 16'd1));
    addVec(32'h88, immWord(OP_ADDI, 21, 0, 16'd4));
    addVec(32'h8C, immWord(OP_BLEZ, 0, 1, 16'd2));
    addVec(32'h90, immWord(OP_BGTZ, 0, 1, 16'd1));
    addVec(32'h94, immWord(OP_ADDI, 21, 0, 16'd5));
    addVec(32'h98, immWord(OP_BGTZ, 0, 2, 16'd2));
    // J, JAL, then JR through the link value
    addVec(32'h9C, jumpWord(OP_J, 26'h2A));
    addVec(32'hA0, immWord(OP_ADDI, 21, 0, 16'd6));
    addVec(32'hA4, immWord(OP_ADDI, 21, 0, 16'd7));
    addVec(32'hA8, jumpWord(OP_JAL, 26'h2D));
    addVec(32'hAC, immWord(OP_ADDI, 31, 0, 16'd0));
    addVec(32'hB0, immWord(OP_ADDI, 21, 0, 16'd8));
    addVec(32'hB4, immWord(OP_ADDI, 22, 31, 16'h0014));
    addVec(32'hB8, rTypeWord(FN_JR, 0, 22, 0, 0));
    addVec(32'hBC, immWord(OP_ADDI, 22, 0, 16'd0));
    addVec(32'hC0, immWord(OP_ADDI, 23, 22, 16'd1));
    addVec(32'hC4, rTypeWord(FN_ADD, 24, 23, 23, 0));
    // REGIMM with an unknown rt
    addVec(32'hC8, immWord(OP_REGIMM, 5, 1, 16'd0));
    // BEQ not taken
    addVec(32'hCC, immWord(OP_BEQ, 2, 1, 16'd3));
    // Backward branch revisits 0x84
    addVec(32'hD0, immWord(OP_BNE, 2, 1, 16'hFFEC));
    addVec(32'hD4, immWord(OP_ADDI, 21, 0, 16'd9));
    addVec(32'h84, immWord(OP_ADDI, 26, 1, 16'd1));
    addVec(32'h88, jumpWord(OP_J, 26'h36));
    addVec(32'h8C, immWord(OP_ADDI, 29, 0, 16'd1));
    addVec(32'hD8, immWord(OP_ADDI, 27, 26, 16'd2));
    addVec(32'hDC, rTypeWord(FN_ADD, 28, 27, 1, 0));
endtask

// ==== coreTb.sv ====
`timescale 1ns/1ns

module coreTb;
    import cpuPkg::*;

    logic   clk = 1'b0;
    logic   rstN;
    logic   inValid;
    inItemT inItem;
    logic   creditRet;
    logic   retValid;
    retireT ret;

    inItemT          vecQ[$];
    retireT          expQ[$];
    logic [31:0]     refRegs [32];
    logic [31:0]     lcgState;
    int              credits;
    int              maxCredits;
    bit              loaded = 1'b0;

    `include "tbVectors.svh"

    pipeCore dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inItem    (inItem),
        .creditRet (creditRet),
        .retValid  (retValid),
        .ret       (ret)
    );

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s: got 0x%h, expected 0x%h", $time, what, got, want);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model, straight from the MIPS rules
    ////////////////////////////////////////////////////////////////////////////

    task automatic buildExpected();
        inItemT      it;
        retireT      r;
        logic [5:0]  opc;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  wreg;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] res;
        logic [31:0] pcNext;
        logic [31:0] tgt;
        logic [31:0] refPc;
        logic        wr;
        logic        taken;
        logic        brTaken;
        logic        ill;
        refPc = RESET_PC;
        for (int k = 0; k < 32; k++) begin
            refRegs[k] = '0;
        end
        foreach (vecQ[i]) begin
            it = vecQ[i];
            // Wrong path, never retires
            if (it.pc != refPc) begin
                continue;
            end
            opc     = it.instr[31:26];
            rs      = it.instr[25:21];
            rt      = it.instr[20:16];
            rd      = it.instr[15:11];
            a       = refRegs[rs];
            b       = refRegs[rt];
            simm    = {{16{it.instr[15]}}, it.instr[15:0]};
            pcNext  = it.pc + 32'd4;
            tgt     = pcNext;
            res     = '0;
            wreg    = '0;
            wr      = 1'b0;
            taken   = 1'b0;
            brTaken = 1'b0;
            ill     = 1'b0;
            case (opc)
                6'h00: begin
                    wr   = 1'b1;
                    wreg = rd;
                    case (it.instr[5:0])
                        6'h20: res = a + b;
                        6'h22: res = a - b;
                        6'h18: res = a * b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h27: res = ~(a | b);
                        6'h26: res = a ^ b;
                        6'h2A: res = {31'b0, $signed(a) < $signed(b)};
                        6'h00: res = b << it.instr[10:6];
                        6'h02: res = b >> it.instr[10:6];
                        // JR
                        6'h08: begin
                            wr    = 1'b0;
                            taken = 1'b1;
                            tgt   = a;
                        end
                        default: begin
                            wr  = 1'b0;
                            ill = 1'b1;
                        end
                    endcase
                end
                // BLTZ and BGEZ by rt
                6'h01: begin
                    if (rt == 5'd0) begin
                        brTaken = a[31];
                    end else if (rt == 5'd1) begin
                        brTaken = !a[31];
                    end else begin
                        ill = 1'b1;
                    end
                end
                6'h04: brTaken = (a == b);
                6'h05: brTaken = (a != b);
                6'h06: brTaken = a[31] || (a == '0);
                6'h07: brTaken = !a[31] && (a != '0);
                6'h02, 6'h03: begin
                    taken = 1'b1;
                    tgt   = {pcNext[31:28], it.instr[25:0], 2'b00};
                    // JAL links into r31
                    if (opc == 6'h03) begin
                        wr   = 1'b1;
                        wreg = 5'd31;
                        res  = pcNext;
                    end
                end
                6'h08, 6'h0A, 6'h0C, 6'h0D, 6'h0E: begin
                    wr   = 1'b1;
                    wreg = rt;
                    case (opc)
                        6'h08:   res = a + simm;
                        6'h0A:   res = {31'b0, $signed(a) < $signed(simm)};
                        6'h0C:   res = a & {16'h0, it.instr[15:0]};
                        6'h0D:   res = a | {16'h0, it.instr[15:0]};
                        default: res = a ^ {16'h0, it.instr[15:0]};
                    endcase
                end
                default: ill = 1'b1;
            endcase
            if (brTaken) begin
                taken = 1'b1;
                tgt   = pcNext + (simm << 2);
            end
            // r0 stays zero
            if (wreg == '0) begin
                wr = 1'b0;
            end
            if (wr) begin
                refRegs[wreg] = res;
            end
            r.pc       = it.pc;
            r.wrEn     = wr;
            r.wrReg    = wr ? wreg : '0;
            r.wrData   = wr ? res : '0;
            r.redirect = taken;
            r.target   = tgt;
            r.illegal  = ill;
            expQ.push_back(r);
            refPc = tgt;
        end
    endtask

    // One falling edge: collect a credit, check a retire
    task automatic fallEdge();
        retireT want;
        @(negedge clk);
        if (creditRet) begin
            credits++;
        end
        if (credits > maxCredits) begin
            $display("Credit count %0d above buffer depth %0d at %0t", credits, maxCredits,
                     $time);
            $display("FAIL: see errors above");
            $fatal(1, "credit overflow");
        end else if (retValid && expQ.size() == 0) begin
            $display("Retire of pc 0x%h at %0t with nothing expected", ret.pc, $time);
            $display("FAIL: see errors above");
            $fatal(1, "extra retire");
        end else if (retValid) begin
            want = expQ.pop_front();
            checkEq("pc", ret.pc, want.pc);
            checkEq("wrEn", ret.wrEn, want.wrEn);
            checkEq("wrReg", ret.wrReg, want.wrReg);
            checkEq("wrData", ret.wrData, want.wrData);
            checkEq("redirect", ret.redirect, want.redirect);
            checkEq("target", ret.target, want.target);
            checkEq("illegal", ret.illegal, want.illegal);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Driver and run control
    ////////////////////////////////////////////////////////////////////////////

    initial begin : mainFlow
        int gap;
        rstN       = 1'b0;
        inValid    = 1'b0;
        inItem     = '0;
        maxCredits = dut0.CREDITS;
        credits    = maxCredits;
        lcgState   = 32'h0442_545a;
        loadVectors();
        buildExpected();
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rstN = 1'b1;

        foreach (vecQ[i]) begin
            // Idle gap of 0 to 3 cycles
            lcgState = lcgNext(lcgState);
            gap      = int'(lcgState[31:30]);
            repeat (gap) begin
                inValid = 1'b0;
                fallEdge();
            end
            inValid = 1'b0;
            while (credits == 0) begin
                fallEdge();
            end
            inValid = 1'b1;
            inItem  = vecQ[i];
            credits--;
            fallEdge();
        end
        inValid = 1'b0;

        // Drain until every expected retire is seen
        while (expQ.size() != 0) begin
            fallEdge();
        end
        // Trailing wrong-path rows leave the buffer one per cycle
        repeat (maxCredits + 4) begin
            fallEdge();
        end
        checkEq("credits returned", credits, maxCredits);
        $display("PASS: all tests");
        $finish;
    end

    // Budget of 20 cycles per table row plus reset
    initial begin : watchdog
        wait (loaded);
        #((vecQ.size() * 20 + 16) * 40);
        $display("Timeout at %0t, retirement stalled", $time);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== compile.f ====
+incdir+.
cpuPkg.sv
instrBuffer.sv
ctrlDecoder.sv
operandStage.sv
execStage.sv
pipeCore.sv
coreTb.sv

// ==== Bender.yml ====
package:
  name: pipe_core

sources:
  - cpuPkg.sv
  - instrBuffer.sv
  - ctrlDecoder.sv
  - operandStage.sv
  - execStage.sv
  - pipeCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - coreTb.sv
